/* source/bmu_pkg.sv */
/*
 * Shared types for the bit-manipulation unit
 * Immediate forms are mapped to register forms by the decoder
 * Codes above BSET are invalid and yield a zero result
 */

package bmu_pkg;

    // Default data width of the core
    localparam int DEFAULT_XLEN = 32;

    // ----------------------------------------------------------
    // Operation code
    // ----------------------------------------------------------

    typedef enum logic [4:0] {
        SH1ADD, SH2ADD, SH3ADD,
        ANDN, ORN, XNOR,
        CLZ, CTZ,
        MAX, MAXU, MIN, MINU,
        SEXTB, SEXTH, ZEXTH,
        ROL, ROR,
        ORCB, REV8,
        BCLR, BEXT, BINV, BSET
    } bmu_op_t;

    // Functional group, picks the unit that owns the result
    typedef enum logic [2:0] {
        NONE,
        ARITH,
        ZCOUNT,
        BIT,
        BYTE
    } bmu_group_t;

    // Control word, issued together with the operands
    typedef struct packed {
        logic    valid;
        bmu_op_t op;
    } bmu_ctrl_t;

    // Map an operation onto the unit that executes it
    function automatic bmu_group_t op_group(bmu_op_t op);
        case (op)
            SH1ADD, SH2ADD, SH3ADD, ANDN, ORN, XNOR,
            MAX, MAXU, MIN, MINU:                       return ARITH;
            CLZ, CTZ:                                   return ZCOUNT;
            ROL, ROR, BCLR, BEXT, BINV, BSET:           return BIT;
            SEXTB, SEXTH, ZEXTH, ORCB, REV8:            return BYTE;
            default:                                    return NONE;
        endcase
    endfunction

endpackage

/* source/bmu_arith_unit.sv */
/*
 * Shift-and-add, inverted logic and min/max
 * One enabled edge from operands to result_o
 */

module bmu_arith_unit #(
    parameter int XLEN = bmu_pkg::DEFAULT_XLEN
) (
    input  logic              clk_i,
    input  logic              clk_en_i,
    input  bmu_pkg::bmu_op_t  op_i,
    input  logic [XLEN - 1:0] operand_a_i,
    input  logic [XLEN - 1:0] operand_b_i,
    output logic [XLEN - 1:0] result_o
);

    // ----------------------------------------------------------
    // Shift-and-add
    // ----------------------------------------------------------

    logic [1:0]        sh_amt;
    logic [XLEN - 1:0] shadd_res;

    // Left shift of operand A by 1, 2 or 3
    always_comb begin
        case (op_i)
            bmu_pkg::SH1ADD: sh_amt = 2'd1;
            bmu_pkg::SH2ADD: sh_amt = 2'd2;
            bmu_pkg::SH3ADD: sh_amt = 2'd3;
            default:         sh_amt = 2'd0;
        endcase
    end

    assign shadd_res = (operand_a_i << sh_amt) + operand_b_i;

    // ----------------------------------------------------------
    // Comparisons for min/max
    // ----------------------------------------------------------

    logic a_lt_b_s;
    logic a_lt_b_u;

    assign a_lt_b_s = $signed(operand_a_i) < $signed(operand_b_i);
    assign a_lt_b_u = operand_a_i < operand_b_i;

    // Result select, foreign codes give zero
    logic [XLEN - 1:0] arith_d;

    always_comb begin
        case (op_i)
            bmu_pkg::SH1ADD,
            bmu_pkg::SH2ADD,
            bmu_pkg::SH3ADD: arith_d = shadd_res;
            // Operand B inverted before the logic op
            bmu_pkg::ANDN:   arith_d = operand_a_i & ~operand_b_i;
            bmu_pkg::ORN:    arith_d = operand_a_i | ~operand_b_i;
            bmu_pkg::XNOR:   arith_d = operand_a_i ^ ~operand_b_i;
            // Selected operand returned as is
            bmu_pkg::MAX:    arith_d = a_lt_b_s ? operand_b_i : operand_a_i;
            bmu_pkg::MAXU:   arith_d = a_lt_b_u ? operand_b_i : operand_a_i;
            bmu_pkg::MIN:    arith_d = a_lt_b_s ? operand_a_i : operand_b_i;
            bmu_pkg::MINU:   arith_d = a_lt_b_u ? operand_a_i : operand_b_i;
            default:         arith_d = '0;
        endcase
    end

    // Stage register
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            result_o <= arith_d;
        end
    end

endmodule

/* source/bmu_zero_count.sv */
/*
 * CLZ and CTZ over one shared leading-zero search
 * An all-zero operand counts as XLEN
 */

module bmu_zero_count #(
    parameter int XLEN = bmu_pkg::DEFAULT_XLEN
) (
    input  logic              clk_i,
    input  logic              clk_en_i,
    input  bmu_pkg::bmu_op_t  op_i,
    input  logic [XLEN - 1:0] operand_a_i,
    output logic [XLEN - 1:0] result_o
);

    // Count needs one extra bit to hold XLEN itself
    localparam int CNT_W = $clog2(XLEN) + 1;

    logic [XLEN - 1:0]  rev_a;
    logic [XLEN - 1:0]  search_a;
    logic [CNT_W - 1:0] lz_cnt;
    logic [CNT_W - 1:0] cnt_q;
    logic               is_zcount;

    // Trailing zeros are leading zeros of the mirrored word
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            rev_a[XLEN - 1 - i] = operand_a_i[i];
        end
    end

    assign search_a = (op_i == bmu_pkg::CTZ) ? rev_a : operand_a_i;

    // ----------------------------------------------------------
    // Priority search, highest set bit wins
    // ----------------------------------------------------------

    always_comb begin
        lz_cnt = CNT_W'(XLEN);
        for (int i = 0; i < XLEN; i++) begin
            if (search_a[i]) begin
                lz_cnt = CNT_W'(XLEN - 1 - i);
            end
        end
    end

    assign is_zcount = (op_i == bmu_pkg::CLZ) || (op_i == bmu_pkg::CTZ);

    // Stage register, only the count bits are stored
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            cnt_q <= is_zcount ? lz_cnt : '0;
        end
    end

    // Zero-extend to the data width
    assign result_o = {{(XLEN - CNT_W){1'b0}}, cnt_q};

endmodule

/* source/bmu_bit_unit.sv */
/*
 * Single-bit ops and rotations
 * Index is the low log2(XLEN) bits of operand B, upper bits ignored
 */

module bmu_bit_unit #(
    parameter int XLEN = bmu_pkg::DEFAULT_XLEN
) (
    input  logic              clk_i,
    input  logic              clk_en_i,
    input  bmu_pkg::bmu_op_t  op_i,
    input  logic [XLEN - 1:0] operand_a_i,
    input  logic [XLEN - 1:0] operand_b_i,
    output logic [XLEN - 1:0] result_o
);

    localparam int IDX_W = $clog2(XLEN);

    logic [IDX_W - 1:0]    index;
    logic [XLEN - 1:0]     mask;
    logic [2 * XLEN - 1:0] rol_wide;
    logic [2 * XLEN - 1:0] ror_wide;
    logic [XLEN - 1:0]     bit_d;

    assign index = operand_b_i[IDX_W - 1:0];

    // One-hot mask at the bit index
    assign mask = {{(XLEN - 1){1'b0}}, 1'b1} << index;

    // ----------------------------------------------------------
    // Rotations through a doubled word
    // ----------------------------------------------------------

    // Index zero leaves operand A in the selected half
    assign rol_wide = {operand_a_i, operand_a_i} << index;
    assign ror_wide = {operand_a_i, operand_a_i} >> index;

    always_comb begin
        case (op_i)
            bmu_pkg::BSET: bit_d = operand_a_i | mask;
            bmu_pkg::BCLR: bit_d = operand_a_i & ~mask;
            bmu_pkg::BINV: bit_d = operand_a_i ^ mask;
            // Extracted bit lands in bit 0
            bmu_pkg::BEXT: bit_d = {{(XLEN - 1){1'b0}}, |(operand_a_i & mask)};
            bmu_pkg::ROL:  bit_d = rol_wide[2 * XLEN - 1:XLEN];
            bmu_pkg::ROR:  bit_d = ror_wide[XLEN - 1:0];
            default:       bit_d = '0;
        endcase
    end

    // Stage register
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            result_o <= bit_d;
        end
    end

endmodule

/* source/bmu_byte_unit.sv */
/*
 * Extensions and byte-wise ops on operand A
 * XLEN must be a multiple of 8 and at least 16
 */

module bmu_byte_unit #(
    parameter int XLEN = bmu_pkg::DEFAULT_XLEN
) (
    input  logic              clk_i,
    input  logic              clk_en_i,
    input  bmu_pkg::bmu_op_t  op_i,
    input  logic [XLEN - 1:0] operand_a_i,
    output logic [XLEN - 1:0] result_o
);

    localparam int NBYTES = XLEN / 8;

    logic [NBYTES - 1:0][7:0] bytes_a;
    logic [NBYTES - 1:0][7:0] orcb_res;
    logic [NBYTES - 1:0][7:0] rev8_res;
    logic [XLEN - 1:0]        byte_d;

    assign bytes_a = operand_a_i;

    // OR-combine within each byte, mirror byte order
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            orcb_res[i]              = {8{|bytes_a[i]}};
            rev8_res[NBYTES - 1 - i] = bytes_a[i];
        end
    end

    always_comb begin
        case (op_i)
            bmu_pkg::SEXTB: byte_d = {{(XLEN - 8){operand_a_i[7]}}, operand_a_i[7:0]};
            bmu_pkg::SEXTH: byte_d = {{(XLEN - 16){operand_a_i[15]}}, operand_a_i[15:0]};
            bmu_pkg::ZEXTH: byte_d = {{(XLEN - 16){1'b0}}, operand_a_i[15:0]};
            bmu_pkg::ORCB:  byte_d = orcb_res;
            bmu_pkg::REV8:  byte_d = rev8_res;
            default:        byte_d = '0;
        endcase
    end

    // Stage register
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            result_o <= byte_d;
        end
    end

endmodule

/* source/bit_manipulation_unit.sv */
/*
 * Single-cycle subset of the RISC-V B extension, fully pipelined
 * Latency is one enabled edge, clk_en_i low holds every stage
 * result_o is undefined until the first enabled edge after reset
 */

module bit_manipulation_unit #(
    parameter int XLEN = bmu_pkg::DEFAULT_XLEN
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               clk_en_i,
    input  bmu_pkg::bmu_ctrl_t ctrl_i,
    input  logic [XLEN - 1:0]  operand_a_i,
    input  logic [XLEN - 1:0]  operand_b_i,
    output logic [XLEN - 1:0]  result_o,
    output logic               valid_o
);

    // Registered group results
    logic [XLEN - 1:0] arith_res;
    logic [XLEN - 1:0] zcount_res;
    logic [XLEN - 1:0] bit_res;
    logic [XLEN - 1:0] byte_res;

    // Control word aligned with the unit results
    bmu_pkg::bmu_ctrl_t ctrl_q;

    // ----------------------------------------------------------
    // Execution units, all fed the same operands
    // ----------------------------------------------------------

    bmu_arith_unit #(.XLEN(XLEN)) u_arith (
        .clk_i       ( clk_i       ),
        .clk_en_i    ( clk_en_i    ),
        .op_i        ( ctrl_i.op   ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .result_o    ( arith_res   )
    );

    bmu_zero_count #(.XLEN(XLEN)) u_zcount (
        .clk_i       ( clk_i       ),
        .clk_en_i    ( clk_en_i    ),
        .op_i        ( ctrl_i.op   ),
        .operand_a_i ( operand_a_i ),
        .result_o    ( zcount_res  )
    );

    bmu_bit_unit #(.XLEN(XLEN)) u_bit (
        .clk_i       ( clk_i       ),
        .clk_en_i    ( clk_en_i    ),
        .op_i        ( ctrl_i.op   ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .result_o    ( bit_res     )
    );

    bmu_byte_unit #(.XLEN(XLEN)) u_byte (
        .clk_i       ( clk_i       ),
        .clk_en_i    ( clk_en_i    ),
        .op_i        ( ctrl_i.op   ),
        .operand_a_i ( operand_a_i ),
        .result_o    ( byte_res    )
    );

    // ----------------------------------------------------------
    // Control stage and result select
    // ----------------------------------------------------------

    // Only valid is cleared, op just holds during reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q.valid <= 1'b0;
        end else if (clk_en_i) begin
            ctrl_q <= ctrl_i;
        end
    end

    assign valid_o = ctrl_q.valid;

    // Invalid codes map to NONE and give zero
    always_comb begin
        case (bmu_pkg::op_group(ctrl_q.op))
            bmu_pkg::ARITH:  result_o = arith_res;
            bmu_pkg::ZCOUNT: result_o = zcount_res;
            bmu_pkg::BIT:    result_o = bit_res;
            bmu_pkg::BYTE:   result_o = byte_res;
            default:         result_o = '0;
        endcase
    end

endmodule

/* test/bmu_tb_model.svh */
/*
 * Expected-value model and compare tasks included inside bmu_tb
 * Expects XLEN, error_count and check_count in the including scope
 */

`ifndef BMU_TB_MODEL_SVH
`define BMU_TB_MODEL_SVH

// Expected result worked out bit by bit from the ISA rules
function automatic logic [XLEN - 1:0] model_result(
    input bmu_pkg::bmu_op_t  op,
    input logic [XLEN - 1:0] a,
    input logic [XLEN - 1:0] b
);
    logic [XLEN - 1:0] r;
    int                idx;
    int                n;
    r   = '0;
    n   = 0;
    // Bit index is b modulo XLEN
    idx = int'(b % XLEN);
    case (op)
        bmu_pkg::SH1ADD: r = a * XLEN'(2) + b;
        bmu_pkg::SH2ADD: r = a * XLEN'(4) + b;
        bmu_pkg::SH3ADD: r = a * XLEN'(8) + b;
        bmu_pkg::ANDN:   r = a & ~b;
        bmu_pkg::ORN:    r = a | ~b;
        bmu_pkg::XNOR:   r = ~(a ^ b);
        bmu_pkg::CLZ: begin
            while (n < XLEN && a[XLEN - 1 - n] == 1'b0) n++;
            r = XLEN'(n);
        end
        bmu_pkg::CTZ: begin
            while (n < XLEN && a[n] == 1'b0) n++;
            r = XLEN'(n);
        end
        bmu_pkg::MAX:    r = ($signed(a) > $signed(b)) ? a : b;
        bmu_pkg::MAXU:   r = (a > b) ? a : b;
        bmu_pkg::MIN:    r = ($signed(a) > $signed(b)) ? b : a;
        bmu_pkg::MINU:   r = (a > b) ? b : a;
        bmu_pkg::SEXTB:  for (int i = 0; i < XLEN; i++) r[i] = (i < 8) ? a[i] : a[7];
        bmu_pkg::SEXTH:  for (int i = 0; i < XLEN; i++) r[i] = (i < 16) ? a[i] : a[15];
        bmu_pkg::ZEXTH:  for (int i = 0; i < 16; i++) r[i] = a[i];
        // Bit i moves to i + idx and wraps around
        bmu_pkg::ROL:    for (int i = 0; i < XLEN; i++) r[(i + idx) % XLEN] = a[i];
        bmu_pkg::ROR:    for (int i = 0; i < XLEN; i++) r[i] = a[(i + idx) % XLEN];
        bmu_pkg::ORCB: begin
            for (int k = 0; k < XLEN / 8; k++) begin
                r[8 * k +: 8] = (a[8 * k +: 8] != 8'h00) ? 8'hff : 8'h00;
            end
        end
        bmu_pkg::REV8: begin
            for (int k = 0; k < XLEN / 8; k++) begin
                r[8 * k +: 8] = a[XLEN - 8 - 8 * k +: 8];
            end
        end
        bmu_pkg::BCLR: begin
            r      = a;
            r[idx] = 1'b0;
        end
        bmu_pkg::BSET: begin
            r      = a;
            r[idx] = 1'b1;
        end
        bmu_pkg::BINV: begin
            r      = a;
            r[idx] = ~a[idx];
        end
        bmu_pkg::BEXT:   r[0] = a[idx];
        // Unlisted codes give zero
        default:         r = '0;
    endcase
    return r;
endfunction

// Data word compare
task automatic check_result(
    input string             name,
    input logic [XLEN - 1:0] actual,
    input logic [XLEN - 1:0] expected
);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
endtask

// Valid strobe compare
task automatic check_valid(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
endtask

`endif

/* test/bmu_tb.sv */
/*
 * Directed testbench for bit_manipulation_unit at the default XLEN
 * Inputs change and outputs are sampled on the falling edge
 * Every task starts and ends just after a falling edge
 */

module bmu_tb;

    localparam int          XLEN          = bmu_pkg::DEFAULT_XLEN;
    localparam int          VALID_TIMEOUT = 20;
    localparam int          RANDOM_OPS    = 200;
    localparam int          STALL_CYCLES  = 5;
    localparam logic [31:0] RAND_SEED     = 32'h1e94_ae28;

    logic               clk_i = 1'b0;
    logic               arst_n_i;
    logic               clk_en_i;
    bmu_pkg::bmu_ctrl_t ctrl_i;
    logic [XLEN - 1:0]  operand_a_i;
    logic [XLEN - 1:0]  operand_b_i;
    logic [XLEN - 1:0]  result_o;
    logic               valid_o;

    int error_count;
    int check_count;
    int test_start_errors;

    `include "bmu_tb_model.svh"

    bit_manipulation_unit #(.XLEN(XLEN)) UUT (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .clk_en_i    ( clk_en_i    ),
        .ctrl_i      ( ctrl_i      ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .result_o    ( result_o    ),
        .valid_o     ( valid_o     )
    );

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------

    function automatic logic [XLEN - 1:0] random_word();
        return XLEN'({$urandom(), $urandom()});
    endfunction

    task automatic issue_op(
        input bmu_pkg::bmu_op_t  op,
        input logic [XLEN - 1:0] a,
        input logic [XLEN - 1:0] b,
        input logic              valid
    );
        clk_en_i     = 1'b1;
        ctrl_i.valid = valid;
        ctrl_i.op    = op;
        operand_a_i  = a;
        operand_b_i  = b;
    endtask

    // Bounded wait for valid_o to rise after one edge
    task automatic wait_valid();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!valid_o && cycles < VALID_TIMEOUT);
        if (!valid_o) begin
            error_count++;
            $display("Timeout: valid_o stayed low for %0d cycles", VALID_TIMEOUT);
        end else if (cycles != 1) begin
            error_count++;
            $display("Latency error: valid_o rose after %0d cycles instead of 1", cycles);
        end
    endtask

    task automatic run_and_check(
        input bmu_pkg::bmu_op_t  op,
        input logic [XLEN - 1:0] a,
        input logic [XLEN - 1:0] b
    );
        issue_op(op, a, b, 1'b1);
        wait_valid();
        check_result("result_o", result_o, model_result(op, a, b));
    endtask

    task automatic report_test(input string name);
        if (error_count == test_start_errors) begin
            $display("Test %-16s ok", name);
        end else begin
            $display("Test %-16s %0d errors", name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------

    task automatic test_reset();
        arst_n_i = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_i);
            check_valid("valid_o", valid_o, 1'b0);
        end
        arst_n_i = 1'b1;
        // Enabled edges with the strobe low keep valid_o low
        issue_op(bmu_pkg::ANDN, '1, '0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk_i);
            check_valid("valid_o", valid_o, 1'b0);
        end
        report_test("reset");
    endtask

    task automatic test_all_ops();
        logic [XLEN - 1:0] corners [6];
        corners[0] = '0;
        corners[1] = '1;
        corners[2] = XLEN'(1) << (XLEN - 1);
        corners[3] = ~corners[2];
        corners[4] = {(XLEN / 16){16'h00c3}};
        // Highest bit index
        corners[5] = XLEN'(XLEN - 1);
        for (int o = 0; o <= int'(bmu_pkg::BSET); o++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++) begin
                    run_and_check(bmu_pkg::bmu_op_t'(5'(o)), corners[i], corners[j]);
                end
            end
        end
        report_test("all_ops");
    endtask

    // One issue per enabled edge and each result checked one cycle later
    task automatic test_random_b2b();
        bmu_pkg::bmu_op_t  op;
        logic [XLEN - 1:0] a;
        logic [XLEN - 1:0] b;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            op = bmu_pkg::bmu_op_t'(5'($urandom_range(int'(bmu_pkg::BSET), 0)));
            a  = random_word();
            b  = random_word();
            issue_op(op, a, b, 1'b1);
            @(negedge clk_i);
            check_valid("valid_o", valid_o, 1'b1);
            check_result("result_o", result_o, model_result(op, a, b));
        end
        report_test("random_b2b");
    endtask

    task automatic test_zero_count();
        logic [XLEN - 1:0] one_hot;
        // Empty operand counts as XLEN
        issue_op(bmu_pkg::CLZ, '0, '0, 1'b1);
        wait_valid();
        check_result("result_o", result_o, XLEN'(XLEN));
        issue_op(bmu_pkg::CTZ, '0, '0, 1'b1);
        wait_valid();
        check_result("result_o", result_o, XLEN'(XLEN));
        for (int k = 0; k < XLEN; k++) begin
            one_hot = XLEN'(1) << k;
            issue_op(bmu_pkg::CLZ, one_hot, '0, 1'b1);
            wait_valid();
            check_result("result_o", result_o, XLEN'(XLEN - 1 - k));
            issue_op(bmu_pkg::CTZ, one_hot, '0, 1'b1);
            wait_valid();
            check_result("result_o", result_o, XLEN'(k));
        end
        report_test("zero_count");
    endtask

    task automatic test_stall();
        logic [XLEN - 1:0] held;
        held = model_result(bmu_pkg::REV8, {(XLEN / 16){16'h1e94}}, '0);
        run_and_check(bmu_pkg::REV8, {(XLEN / 16){16'h1e94}}, '0);
        // Inputs keep changing while the stage is frozen
        clk_en_i     = 1'b0;
        ctrl_i.valid = 1'b0;
        ctrl_i.op    = bmu_pkg::CLZ;
        for (int i = 0; i < STALL_CYCLES; i++) begin
            operand_a_i = random_word();
            operand_b_i = random_word();
            @(negedge clk_i);
            check_valid("valid_o", valid_o, 1'b1);
            check_result("result_o", result_o, held);
        end
        run_and_check(bmu_pkg::MINU, random_word(), random_word());
        report_test("clk_en_stall");
    endtask

    // Unlisted codes give zero while valid_o follows the strobe
    task automatic test_invalid_code();
        for (int code = int'(bmu_pkg::BSET) + 1; code < 32; code++) begin
            issue_op(bmu_pkg::bmu_op_t'(5'(code)), '1, '1, code[0]);
            @(negedge clk_i);
            check_valid("valid_o", valid_o, code[0]);
            check_result("result_o", result_o, '0);
        end
        report_test("invalid_code");
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        error_count       = 0;
        check_count       = 0;
        test_start_errors = 0;
        arst_n_i          = 1'b0;
        clk_en_i          = 1'b0;
        ctrl_i            = '0;
        operand_a_i       = '0;
        operand_b_i       = '0;
        test_reset();
        test_all_ops();
        test_random_b2b();
        test_zero_count();
        test_stall();
        test_invalid_code();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bit_manipulation_unit.f */
+incdir+test
source/bmu_pkg.sv
source/bmu_arith_unit.sv
source/bmu_zero_count.sv
source/bmu_bit_unit.sv
source/bmu_byte_unit.sv
source/bit_manipulation_unit.sv
test/bmu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the bmu_tb testbench with Verilator, runs it and checks the log

ROOT_DIR="$(cd "$(dirname "$0")" && pwd)"
BUILD_DIR=obj_dir
LOG_FILE=sim.log

cd "$ROOT_DIR"
if [ $? -ne 0 ]; then
    echo "Cannot enter project root $ROOT_DIR"
    exit 1
fi

verilator --binary --timing --top-module bmu_tb -Mdir "$BUILD_DIR" -f bit_manipulation_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vbmu_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
